// File: logic/spi_pkg.sv
package spi_pkg;

  // the length field is one bit short of holding MAX_CHAR, so zero stands for it
  localparam int CHAR_LEN_BITS = 5;
  localparam int MAX_CHAR = 2 ** CHAR_LEN_BITS;

  // one half period of the serial clock lasts clk_div + 1 system clocks
  localparam int DIV_BITS = 8;

  // transmit and receive words
  typedef logic [MAX_CHAR-1:0] spi_word_t;

  // requested character length
  typedef logic [CHAR_LEN_BITS-1:0] char_len_t;

  // remaining bits in a transfer, wide enough for MAX_CHAR itself
  typedef logic [CHAR_LEN_BITS:0] bit_cnt_t;

  // serial clock divider setting
  typedef logic [DIV_BITS-1:0] clk_div_t;

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    RUN,
    FINISH
  } ctrl_state_t;

  // number of bits in a character, with a zero length read as MAX_CHAR
  function automatic bit_cnt_t char_bits(input char_len_t len);
    if (len == '0) begin
      return bit_cnt_t'(MAX_CHAR);
    end
    return bit_cnt_t'(len);
  endfunction

endpackage

// File: logic/spi_edge_if.sv
`timescale 1ns/1ps

interface spi_edge_if;
  // strobes lead the matching s_clk change by one system clock
  logic pos_edge;
  logic neg_edge;
  logic s_clk;
  logic tip;
  logic last;

  modport gen (
    output pos_edge,
    output neg_edge,
    output s_clk,
    input  tip,
    input  last
  );

  modport shift (
    output tip,
    output last,
    input  pos_edge,
    input  neg_edge,
    input  s_clk
  );
endinterface

// File: logic/spi_clock_gen.sv
`timescale 1ns/1ps

module spi_clock_gen
  import spi_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  clk_div_t clk_div,
  spi_edge_if.gen  edge_bus
);

  clk_div_t cnt;
  logic     half_done;
  logic     final_edge;
  logic     toggle;
  logic     s_clk_next;

  // the rising strobe at the last bit only ends the transfer, sclk stays low
  assign final_edge = edge_bus.pos_edge && edge_bus.last;
  assign toggle = edge_bus.neg_edge || (edge_bus.pos_edge && !edge_bus.last);
  assign s_clk_next = edge_bus.s_clk ^ toggle;

  // no further strobes are scheduled once the final edge is out
  assign half_done = (cnt == clk_div) && !final_edge;

  always_ff @(posedge clk) begin
    if (rst || !edge_bus.tip) begin
      cnt <= '0;
    end else if (cnt == clk_div) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + clk_div_t'(1);
    end
  end

  // s_clk moves at the end of each strobe cycle, so the strobes are set
  // from the level that s_clk is about to take
  always_ff @(posedge clk) begin
    if (rst || !edge_bus.tip) begin
      edge_bus.s_clk <= 1'b0;
      edge_bus.pos_edge <= 1'b0;
      edge_bus.neg_edge <= 1'b0;
    end else begin
      edge_bus.s_clk <= s_clk_next;
      edge_bus.pos_edge <= half_done && !s_clk_next;
      edge_bus.neg_edge <= half_done && s_clk_next;
    end
  end

  // a rising and a falling serial edge never share a cycle
  a_edges_exclusive: assert property (
    @(posedge clk) disable iff (rst)
    !(edge_bus.pos_edge && edge_bus.neg_edge)
  );

  // strobes stay quiet while the shifter has no transfer going
  a_quiet_without_tip: assert property (
    @(posedge clk) disable iff (rst)
    !edge_bus.tip |-> !edge_bus.pos_edge && !edge_bus.neg_edge && !edge_bus.s_clk
  );

endmodule

// File: logic/spi_shifter.sv
`timescale 1ns/1ps

module spi_shifter
  import spi_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  char_len_t len,
  input  logic      lsb,
  input  logic      go,
  input  logic      rx_negedge,
  input  logic      tx_negedge,
  input  logic      miso,
  output logic      mosi,
  input  spi_word_t mosi_data,
  output spi_word_t miso_data,
  spi_edge_if.shift edge_bus
);

  bit_cnt_t  cnt;
  spi_word_t tx_reg;
  spi_word_t tx_src;
  logic      tx_sel_edge;
  logic      rx_sel_edge;
  logic      tx_clk;
  logic      rx_clk;
  logic      launch;
  logic      shift_out;

  assign edge_bus.last = (cnt == '0);

  assign tx_sel_edge = tx_negedge ? edge_bus.neg_edge : edge_bus.pos_edge;
  assign rx_sel_edge = rx_negedge ? edge_bus.neg_edge : edge_bus.pos_edge;

  assign tx_clk = tx_sel_edge && !edge_bus.last;

  // a falling strobe at the last bit still sees s_clk high and takes the final bit
  assign rx_clk = rx_sel_edge && (!edge_bus.last || edge_bus.s_clk);

  // transmitting on falling edges needs the first bit on mosi before the first
  // rising edge, so it leaves together with go
  assign launch = go && !edge_bus.tip && tx_negedge;
  assign shift_out = (edge_bus.tip && tx_clk) || launch;
  assign tx_src = edge_bus.tip ? tx_reg : mosi_data;

  always_ff @(posedge clk) begin
    if (rst || !edge_bus.tip) begin
      cnt <= char_bits(len);
    end else if (edge_bus.pos_edge && !edge_bus.last) begin
      cnt <= cnt - bit_cnt_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      edge_bus.tip <= 1'b0;
    end else if (go && !edge_bus.tip) begin
      edge_bus.tip <= 1'b1;
    end else if (edge_bus.tip && edge_bus.last && edge_bus.pos_edge) begin
      edge_bus.tip <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mosi <= 1'b0;
    end else if (shift_out) begin
      mosi <= lsb ? tx_src[0] : tx_src[MAX_CHAR-1];
    end
  end

  // ones fill in behind the data in either direction
  always_ff @(posedge clk) begin
    if (shift_out) begin
      if (lsb) begin
        tx_reg <= {1'b1, tx_src[MAX_CHAR-1:1]};
      end else begin
        tx_reg <= {tx_src[MAX_CHAR-2:0], 1'b1};
      end
    end else if (!edge_bus.tip) begin
      tx_reg <= mosi_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rx_clk) begin
      miso_data <= {miso_data[MAX_CHAR-2:0], miso};
    end
  end

  // a transfer only begins on request from the control block
  a_tip_after_go: assert property (
    @(posedge clk) disable iff (rst)
    $rose(edge_bus.tip) |-> $past(go)
  );

  // between transfers the counter just holds the reload value
  a_cnt_idle_hold: assert property (
    @(posedge clk) disable iff (rst)
    (!edge_bus.tip && $past(!edge_bus.tip) && !go) |=> $stable(cnt)
  );

endmodule

// File: logic/spi_ctrl.sv
`timescale 1ns/1ps

module spi_ctrl
  import spi_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  spi_word_t tx_data,
  input  char_len_t char_len,
  input  logic      lsb_first,
  input  logic      rx_negedge,
  input  logic      tx_negedge,
  input  clk_div_t  clk_div_in,
  output logic      busy,
  output logic      done,
  output logic      ss_n,
  output spi_word_t rx_data,
  output logic      go,
  output logic      lsb,
  output logic      sh_rx_negedge,
  output logic      sh_tx_negedge,
  output char_len_t len,
  output clk_div_t  clk_div,
  output spi_word_t mosi_data,
  input  spi_word_t miso_data,
  input  logic      tip
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  spi_word_t   tx_q;
  spi_word_t   len_mask;
  bit_cnt_t    n_bits;
  logic        tip_seen;
  logic        run_done;

  assign n_bits = char_bits(len);

  // left-justify so that bit n-1 of the word is the first to leave
  assign mosi_data = lsb ? tx_q : (tx_q << (bit_cnt_t'(MAX_CHAR) - n_bits));

  // earlier bits of the receive register sit above the character and are dropped
  assign len_mask = (len == '0) ? '1 : ((spi_word_t'(1) << len) - spi_word_t'(1));

  assign run_done = (state == RUN) && tip_seen && !tip;

  assign go = (state == LOAD);
  assign busy = (state != IDLE);
  assign done = (state == FINISH);
  assign ss_n = (state == IDLE);

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (start) begin
          state_next = LOAD;
        end
      end
      LOAD: begin
        state_next = RUN;
      end
      RUN: begin
        if (run_done) begin
          state_next = FINISH;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      tip_seen <= 1'b0;
    end else begin
      state <= state_next;
      tip_seen <= (state == RUN) && (tip_seen || tip);
    end
  end

  // settings are frozen for the whole transfer, later starts are not sampled
  always_ff @(posedge clk) begin
    if (rst) begin
      lsb <= 1'b0;
      sh_rx_negedge <= 1'b0;
      sh_tx_negedge <= 1'b0;
      len <= '0;
      clk_div <= '0;
    end else if (state == IDLE && start) begin
      lsb <= lsb_first;
      sh_rx_negedge <= rx_negedge;
      sh_tx_negedge <= tx_negedge;
      len <= char_len;
      clk_div <= clk_div_in;
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
      tx_q <= tx_data;
    end
  end

  // the word is ready in the same cycle as done
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_data <= '0;
    end else if (run_done) begin
      rx_data <= miso_data & len_mask;
    end
  end

  // FINISH, and with it done, follows only a completed run of the shifter
  a_done_after_run: assert property (
    @(posedge clk) disable iff (rst)
    done |-> !tip && $past(state == RUN)
  );

endmodule

// File: logic/spi_master_top.sv
`timescale 1ns/1ps

module spi_master_top
  import spi_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  spi_word_t tx_data,
  input  char_len_t char_len,
  input  logic      lsb_first,
  input  logic      rx_negedge,
  input  logic      tx_negedge,
  input  clk_div_t  clk_div,
  output logic      busy,
  output logic      done,
  output spi_word_t rx_data,
  output logic      sclk,
  output logic      mosi,
  output logic      ss_n,
  input  logic      miso
);

  logic      go;
  logic      lsb;
  logic      sh_rx_negedge;
  logic      sh_tx_negedge;
  char_len_t len;
  clk_div_t  sh_clk_div;
  spi_word_t mosi_data;
  spi_word_t miso_data;

  spi_edge_if edge_bus ();

  assign sclk = edge_bus.s_clk;

  spi_ctrl u_spi_ctrl (
    .clk           (clk),
    .rst           (rst),
    .start         (start),
    .tx_data       (tx_data),
    .char_len      (char_len),
    .lsb_first     (lsb_first),
    .rx_negedge    (rx_negedge),
    .tx_negedge    (tx_negedge),
    .clk_div_in    (clk_div),
    .busy          (busy),
    .done          (done),
    .ss_n          (ss_n),
    .rx_data       (rx_data),
    .go            (go),
    .lsb           (lsb),
    .sh_rx_negedge (sh_rx_negedge),
    .sh_tx_negedge (sh_tx_negedge),
    .len           (len),
    .clk_div       (sh_clk_div),
    .mosi_data     (mosi_data),
    .miso_data     (miso_data),
    .tip           (edge_bus.tip)
  );

  spi_clock_gen u_spi_clock_gen (
    .clk      (clk),
    .rst      (rst),
    .clk_div  (sh_clk_div),
    .edge_bus (edge_bus.gen)
  );

  spi_shifter u_spi_shifter (
    .clk        (clk),
    .rst        (rst),
    .len        (len),
    .lsb        (lsb),
    .go         (go),
    .rx_negedge (sh_rx_negedge),
    .tx_negedge (sh_tx_negedge),
    .miso       (miso),
    .mosi       (mosi),
    .mosi_data  (mosi_data),
    .miso_data  (miso_data),
    .edge_bus   (edge_bus.shift)
  );

endmodule

// File: verif/tb_spi_master.sv
`timescale 1ns/1ps

module tb_spi_master
  import spi_pkg::*;
();

  localparam int WAIT_LIMIT = 2000;

  logic      clk;
  logic      rst;
  logic      start;
  spi_word_t tx_data;
  char_len_t char_len;
  logic      lsb_first;
  logic      rx_negedge;
  logic      tx_negedge;
  clk_div_t  clk_div;
  logic      busy;
  logic      done;
  spi_word_t rx_data;
  logic      sclk;
  logic      mosi;
  logic      ss_n;

  integer seed;
  int     passes;
  int     fails;
  int     test_errors;
  logic   timed_out;

  logic mon_en;
  logic sclk_prev;
  int   since_change;
  int   changes;
  int   rises;
  int   done_count;
  int   ss_gaps;
  int   half_min;
  int   half_max;

  // miso is fed straight from mosi
  spi_master_top u_spi_master_top (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .tx_data    (tx_data),
    .char_len   (char_len),
    .lsb_first  (lsb_first),
    .rx_negedge (rx_negedge),
    .tx_negedge (tx_negedge),
    .clk_div    (clk_div),
    .busy       (busy),
    .done       (done),
    .rx_data    (rx_data),
    .sclk       (sclk),
    .mosi       (mosi),
    .ss_n       (ss_n),
    .miso       (mosi)
  );

  always #2 clk = ~clk;

  // serial clock and framing are watched on the falling system clock edge
  always @(negedge clk) begin
    if (mon_en) begin
      if (done) done_count++;
      if (busy && ss_n) ss_gaps++;
      since_change++;
      if (sclk !== sclk_prev) begin
        if (sclk) rises++;
        if (changes > 0) begin
          if (since_change < half_min) half_min = since_change;
          if (since_change > half_max) half_max = since_change;
        end
        changes++;
        since_change = 0;
        sclk_prev = sclk;
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("Error: %s got %h expected %h", name, got, expected);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string what);
    if (test_errors == 0) begin
      passes++;
      $display("%s: ok", what);
    end else begin
      fails++;
      $display("%s: FAILED with %0d errors", what, test_errors);
    end
  endtask

  task automatic wait_for_done(output logic ok);
    int cycles;
    cycles = 0;
    while (done_count == 0 && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    ok = (done_count != 0);
  endtask

  task automatic wait_for_idle(output logic ok);
    int cycles;
    cycles = 0;
    while (busy !== 1'b0 && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    ok = (busy === 1'b0);
  endtask

  task automatic run_transfer(input int idx, input int len_f, input int lsb_v, input int rxn,
                              input int txn, input int div, input spi_word_t tx,
                              input spi_word_t exp);
    int   n;
    int   gap;
    logic ok;
    n = (len_f == 0) ? MAX_CHAR : len_f;
    test_errors = 0;
    gap = $unsigned($random(seed)) % 4;
    repeat (gap) @(posedge clk);
    @(posedge clk);
    #1;
    mon_en = 1'b0;
    sclk_prev = sclk;
    since_change = 0;
    changes = 0;
    rises = 0;
    done_count = 0;
    ss_gaps = 0;
    half_min = WAIT_LIMIT;
    half_max = 0;
    mon_en = 1'b1;
    tx_data = tx;
    char_len = char_len_t'(len_f);
    lsb_first = lsb_v[0];
    rx_negedge = rxn[0];
    tx_negedge = txn[0];
    clk_div = clk_div_t'(div);
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    // a second start with other settings lands in the middle of the transfer
    gap = 1 + $unsigned($random(seed)) % 4;
    repeat (gap) @(posedge clk);
    #1;
    if (busy) begin
      tx_data = ~tx;
      char_len = char_len_t'(len_f + 3);
      lsb_first = ~lsb_v[0];
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
    end
    wait_for_done(ok);
    if (ok) wait_for_idle(ok);
    if (!ok) begin
      $display("test %0d: timed out waiting for the transfer to end", idx);
      test_errors++;
      timed_out = 1'b1;
    end else begin
      repeat (3) @(posedge clk);
      #1;
      mon_en = 1'b0;
      check_value("rx_data", rx_data, exp);
      check_value("done_pulses", done_count, 1);
      check_value("sclk_rises", rises, n);
      check_value("sclk_half_min", half_min, div + 1);
      check_value("sclk_half_max", half_max, div + 1);
      check_value("ss_n_high_while_busy", ss_gaps, 0);
    end
    finish_test($sformatf("test %0d len %0d lsb %0d rxn %0d txn %0d div %0d",
                          idx, n, lsb_v, rxn, txn, div));
  endtask

  initial begin
    string     line;
    int        fd;
    int        count;
    int        idx;
    int        len_f;
    int        lsb_v;
    int        rxn;
    int        txn;
    int        div;
    spi_word_t tx;
    spi_word_t exp;
    seed = 37024;
    passes = 0;
    fails = 0;
    timed_out = 1'b0;
    mon_en = 1'b0;
    clk = 1'b0;
    rst = 1'b1;
    start = 1'b0;
    tx_data = '0;
    char_len = '0;
    lsb_first = 1'b0;
    rx_negedge = 1'b0;
    tx_negedge = 1'b1;
    clk_div = '0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    test_errors = 0;
    check_value("busy", busy, 0);
    check_value("done", done, 0);
    check_value("sclk", sclk, 0);
    check_value("mosi", mosi, 0);
    check_value("ss_n", ss_n, 1);
    finish_test("reset state");

    idx = 0;
    fd = $fopen("verif/spi_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file");
      fails++;
    end else begin
      while (!timed_out && $fgets(line, fd) != 0) begin
        if (line.len() == 0 || line.substr(0, 0) == "#") continue;
        count = $sscanf(line, "%d %d %d %d %d %h %h", len_f, lsb_v, rxn, txn, div, tx, exp);
        if (count == 7) begin
          idx++;
          run_transfer(idx, len_f, lsb_v, rxn, txn, div, tx, exp);
        end
      end
      $fclose(fd);
      if (idx == 0) begin
        $display("the stimulus file held no transfers");
        fails++;
      end
    end

    $display("tests passed: %0d, tests failed: %0d", passes, fails);
    if (fails == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: verif/spi_stimulus.txt
# len lsb_first rx_negedge tx_negedge clk_div tx_data(hex) expected_rx_data(hex)
# len 0 stands for 32 bits
8 0 0 1 0 A5C35A96 00000096
8 0 1 0 3 123456E7 000000E7
16 0 0 1 3 DEADBEEF 0000BEEF
16 0 1 0 0 0F0F3C5A 00003C5A
0 0 0 1 0 89ABCDEF 89ABCDEF
0 0 1 0 3 F00D1234 F00D1234
8 1 0 1 0 FFFFFF01 00000080
8 1 1 0 3 000000C5 000000A3
5 1 0 1 3 12345613 00000019
5 1 1 0 0 ABCDEF06 0000000C
0 1 0 1 0 00000001 80000000
0 1 1 0 3 12345678 1E6A2C48
1 0 0 1 2 FFFFFFFF 00000001
3 1 1 0 1 00000006 00000003
31 0 1 0 1 FFFF0000 7FFF0000
16 1 0 1 0 00008001 00008001
12 0 0 1 3 00000ABC 00000ABC
12 1 1 0 0 00000ABC 000003D5

// File: sim.f
logic/spi_pkg.sv
logic/spi_edge_if.sv
logic/spi_clock_gen.sv
logic/spi_shifter.sv
logic/spi_ctrl.sv
logic/spi_master_top.sv
verif/tb_spi_master.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_spi_master -f sim.f \
    --Mdir "$BUILD_DIR" -o sim_tb; then
  echo "build failed"
  exit 1
fi

if ! "./$BUILD_DIR/sim_tb" > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation ended with an error status"
  exit 1
fi

cat "$LOG"

if grep -q "All tests passed" "$LOG"; then
  echo "PASS"
  exit 0
fi

echo "FAIL"
exit 1
